// ==== bench/tcdm_patterns.mem ====
// group master op address wdata be expected
// op 1 is a read and op 0 is a write
// lines of one group are issued in the same cycle and group FF ends the list
01 0 0 00000020 11111111 F 00000000
01 1 0 00000024 22222222 F 00000000
01 2 0 00000028 33333333 F 00000000
01 3 0 0000002C 44444444 F 00000000
02 0 1 0000002C 00000000 F 44444444
02 1 1 00000028 00000000 F 33333333
02 2 1 00000024 00000000 F 22222222
02 3 1 00000020 00000000 F 11111111
03 1 0 00000050 AABBCCDD F 00000000
04 2 0 00000050 11223344 5 00000000
05 3 0 00000050 55667788 8 00000000
06 0 1 00000050 00000000 F 5522CC44
07 2 0 00000054 CAFEF00D F 00000000
08 3 0 00000054 12345678 6 00000000
09 1 1 00000054 00000000 F CA34560D
0A 3 0 F0000030 0BADCAFE F 00000000
0B 0 1 00000030 00000000 F 0BADCAFE
0C 0 0 0000007C A0A0A0A0 F 00000000
0C 1 0 0000009C B1B1B1B1 F 00000000
0C 2 0 000000BC C2C2C2C2 F 00000000
0C 3 0 000000DC D3D3D3D3 F 00000000
0D 0 1 000000DC 00000000 F D3D3D3D3
0D 1 1 000000BC 00000000 F C2C2C2C2
0D 2 1 0000009C 00000000 F B1B1B1B1
0D 3 1 0000007C 00000000 F A0A0A0A0
0E 0 1 00000020 00000000 F 11111111
0E 1 1 00000024 00000000 F 22222222
0E 2 0 00000020 77777777 F 00000000
0F 3 1 00000020 00000000 F 77777777
FF 0 0 00000000 00000000 0 00000000

// ==== all.f ====
src/tcdm_pkg.sv
src/tcdm_rr_arbiter.sv
src/tcdm_sram_bank.sv
src/tcdm_resp_router.sv
src/tcdm_xbar.sv
src/tcdm_cluster_top.sv
bench/tb_tcdm_cluster.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the TCDM cluster testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing -f all.f --top-module tb_tcdm_cluster -Mdir obj_dir \
   > build.log 2>&1 \
   && ./obj_dir/Vtb_tcdm_cluster > sim.log 2>&1

# The log decides the result
grep -q "ALL CHECKS PASSED" sim.log 2>/dev/null \
   && { echo "Simulation passed"; exit 0; } \
   || { echo "Simulation failed, see build.log and sim.log"; exit 1; }

// ==== bench/tb_tcdm_cluster.sv ====
//******************************
// TCDM cluster testbench
// Pattern file, reference memory and random traffic
//******************************

`timescale 1ns/100ps
`default_nettype none

module tb_tcdm_cluster;

   import tcdm_pkg::*;

   localparam int N_MASTERS  = 4;
   localparam int N_BANKS    = 8;
   localparam int ROW_WIDTH  = 6;
   localparam int WORDS      = N_BANKS * (2 ** ROW_WIDTH);
   localparam int IDX_W      = $clog2(WORDS);
   localparam int BANK_W     = $clog2(N_BANKS);
   localparam int PAT_FIELDS = 7;
   localparam int PAT_MAX    = 64;
   localparam int N_RANDOM   = 200;
   localparam int GNT_LIMIT  = 16;
   localparam int HALF       = 10;

   logic                  clk;
   logic                  reset;
   logic [N_MASTERS-1:0]  req;
   addr_t [N_MASTERS-1:0] add;
   logic [N_MASTERS-1:0]  wen;
   data_t [N_MASTERS-1:0] wdata;
   be_t [N_MASTERS-1:0]   be;
   logic [N_MASTERS-1:0]  gnt;
   logic [N_MASTERS-1:0]  r_valid;
   data_t [N_MASTERS-1:0] r_rdata;

   // Seven words per pattern line
   logic [31:0] pat_mem [PAT_FIELDS*PAT_MAX];
   int          n_lines;
   bit          loaded;

   // Reference memory with per byte written flags
   data_t       ref_mem [WORDS];
   be_t         ref_known [WORDS];
   // Model of each bank's priority pointer
   int          ptr [N_BANKS];

   // Pattern word to compare for each pending read
   logic [N_MASTERS-1:0]  chk_exp;
   data_t [N_MASTERS-1:0] exp_word;

   int          err_count;
   integer      seed;

   tcdm_cluster_top
   #(
      .N_MASTERS ( N_MASTERS ),
      .N_BANKS   ( N_BANKS   ),
      .ROW_WIDTH ( ROW_WIDTH )
   )
   u_tcdm_cluster_top
   (
      .clk_i     ( clk       ),
      .reset_i   ( reset     ),
      .req_i     ( req       ),
      .add_i     ( add       ),
      .wen_i     ( wen       ),
      .wdata_i   ( wdata     ),
      .be_i      ( be        ),
      .gnt_o     ( gnt       ),
      .r_valid_o ( r_valid   ),
      .r_rdata_o ( r_rdata   )
   );

   initial
   begin : clock_gen
      clk = 1'b0;
      forever
         #HALF clk = ~clk;
   end

   //******************************
   // Helpers
   //******************************

   // Word slot covered by the bank and row fields
   function automatic int word_index(input addr_t a);
      return int'(a[BYTE_OFFSET +: IDX_W]);
   endfunction

   function automatic int bank_of(input addr_t a);
      return int'(a[BYTE_OFFSET +: BANK_W]);
   endfunction

   // One byte of ones per enable bit
   function automatic data_t lane_mask(input be_t lanes);
      data_t mask;
      for (int b = 0; b < 4; b++)
         mask[b*8 +: 8] = {8{lanes[b]}};
      return mask;
   endfunction

   task automatic check_value(input data_t actual, input data_t expected, input string what);
      if (actual !== expected)
      begin
         err_count++;
         $display("CHECK FAILED at %0t ns: %s, got %h, expected %h",
                  $time, what, actual, expected);
      end
   endtask

   // First requester at or above the pointer wins, pointer moves past it
   task automatic model_arbiters(output logic [N_MASTERS-1:0] exp_gnt);
      int cand;
      bit found;
      exp_gnt = '0;
      for (int b = 0; b < N_BANKS; b++)
      begin
         found = 1'b0;
         for (int k = 0; k < N_MASTERS; k++)
         begin
            cand = (ptr[b] + k) % N_MASTERS;
            if (!found && req[cand] && bank_of(add[cand]) == b)
            begin
               exp_gnt[cand] = 1'b1;
               ptr[b]        = (cand + 1) % N_MASTERS;
               found         = 1'b1;
            end
         end
      end
   endtask

   //******************************
   // Request engine
   //******************************

   // Entered just after a falling edge, leaves on one
   task automatic run_requests();
      logic [N_MASTERS-1:0] exp_gnt;
      logic [N_MASTERS-1:0] took;
      logic [N_MASTERS-1:0] rd_chk;
      data_t                rd_exp [N_MASTERS];
      data_t                rd_mask [N_MASTERS];
      int                   wait_cnt [N_MASTERS];
      int                   idx;
      for (int m = 0; m < N_MASTERS; m++)
         wait_cnt[m] = 0;
      while (req != '0)
      begin
         // Grants settle before the rising edge
         #(HALF - 1);
         model_arbiters(exp_gnt);
         check_value(data_t'(gnt), data_t'(exp_gnt), "grant vector");
         took   = gnt;
         rd_chk = '0;
         // Reads see the word before this edge
         for (int m = 0; m < N_MASTERS; m++)
         begin
            idx = word_index(add[m]);
            if (took[m] && wen[m])
            begin
               rd_chk[m]  = 1'b1;
               rd_exp[m]  = ref_mem[idx];
               rd_mask[m] = lane_mask(ref_known[idx]);
            end
         end
         for (int m = 0; m < N_MASTERS; m++)
         begin
            idx = word_index(add[m]);
            if (took[m] && !wen[m])
            begin
               ref_mem[idx]   = (ref_mem[idx] & ~lane_mask(be[m])) | (wdata[m] & lane_mask(be[m]));
               ref_known[idx] = ref_known[idx] | be[m];
            end
         end
         @(posedge clk);
         #1;
         check_value(data_t'(r_valid), data_t'(exp_gnt), "r_valid one cycle after grant");
         for (int m = 0; m < N_MASTERS; m++)
         begin
            if (rd_chk[m])
            begin
               check_value(r_rdata[m] & rd_mask[m], rd_exp[m] & rd_mask[m],
                           $sformatf("master %0d read data against reference memory", m));
               if (chk_exp[m])
                  check_value(r_rdata[m], exp_word[m],
                              $sformatf("master %0d read data against pattern", m));
            end
         end
         @(negedge clk);
         // Winners drop out, losers hold their request
         for (int m = 0; m < N_MASTERS; m++)
         begin
            if (took[m])
               req[m] = 1'b0;
            else if (req[m])
            begin
               wait_cnt[m]++;
               if (wait_cnt[m] >= GNT_LIMIT)
               begin
                  err_count++;
                  $display("Master %0d got no grant within %0d cycles at %0t ns",
                           m, GNT_LIMIT, $time);
                  req[m] = 1'b0;
               end
            end
         end
      end
   endtask

   //******************************
   // Test phases
   //******************************

   task automatic reset_idle();
      repeat (5) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      // Nothing may move without a request
      repeat (6)
      begin
         #(HALF - 1);
         check_value(data_t'(gnt), '0, "grant while idle");
         @(posedge clk);
         #1;
         check_value(data_t'(r_valid), '0, "r_valid while idle");
         @(negedge clk);
      end
   endtask

   // Lines with the same group start in the same cycle
   task automatic play_patterns();
      int line;
      int base;
      int m;
      logic [31:0] grp;
      line = 0;
      while (line < n_lines)
      begin
         grp     = pat_mem[line*PAT_FIELDS];
         chk_exp = '0;
         while (line < n_lines && pat_mem[line*PAT_FIELDS] == grp)
         begin
            base = line * PAT_FIELDS;
            m    = int'(pat_mem[base+1]);
            if (m >= N_MASTERS)
            begin
               err_count++;
               $display("Pattern line %0d names master %0d, which does not exist", line, m);
            end
            else
            begin
               req[m]      = 1'b1;
               wen[m]      = pat_mem[base+2][0];
               add[m]      = pat_mem[base+3];
               wdata[m]    = pat_mem[base+4];
               be[m]       = be_t'(pat_mem[base+5]);
               exp_word[m] = pat_mem[base+6];
               chk_exp[m]  = pat_mem[base+2][0];
            end
            line++;
         end
         run_requests();
      end
   endtask

   task automatic random_traffic();
      logic [31:0] rnd;
      chk_exp = '0;
      for (int r = 0; r < N_RANDOM; r++)
      begin
         for (int m = 0; m < N_MASTERS; m++)
         begin
            rnd      = $random(seed);
            req[m]   = rnd[0];
            wen[m]   = rnd[1];
            be[m]    = (rnd[7:4] == 4'h0) ? 4'hF : rnd[7:4];
            // Four rows per bank, upper bits left random
            add[m]   = $random(seed) & 32'hFFFF_F87C;
            wdata[m] = $random(seed);
         end
         if (req == '0)
            req[r % N_MASTERS] = 1'b1;
         run_requests();
      end
   endtask

   //******************************
   // Main sequence
   //******************************

   initial
   begin : main
      seed      = 32'h9019;
      err_count = 0;
      loaded    = 1'b0;
      reset     = 1'b1;
      req       = '0;
      add       = '0;
      wen       = '0;
      wdata     = '0;
      be        = '0;
      chk_exp   = '0;
      exp_word  = '0;
      for (int i = 0; i < WORDS; i++)
      begin
         ref_mem[i]   = '0;
         ref_known[i] = '0;
      end
      for (int b = 0; b < N_BANKS; b++)
         ptr[b] = 0;
      $readmemh("bench/tcdm_patterns.mem", pat_mem);
      // Group FF closes the list
      n_lines = 0;
      while (n_lines < PAT_MAX && pat_mem[n_lines*PAT_FIELDS] !== 32'hFF &&
             !$isunknown(pat_mem[n_lines*PAT_FIELDS]))
         n_lines++;
      loaded = 1'b1;
      if (n_lines == 0)
      begin
         err_count++;
         $display("No pattern lines were read from bench/tcdm_patterns.mem");
      end
      reset_idle();
      play_patterns();
      random_traffic();
      $display("Run complete with %0d errors", err_count);
      if (err_count == 0)
         $display("ALL CHECKS PASSED");
      else
         $display("CHECKS FAILED");
      $finish;
   end

   // Budget of 20 cycles per access
   initial
   begin : watchdog
      longint limit_ns;
      wait (loaded);
      limit_ns = longint'(n_lines + N_RANDOM * N_MASTERS + 20) * 20 * 20;
      #(limit_ns);
      $display("Watchdog expired after %0d ns, the run did not complete", limit_ns);
      $display("CHECKS FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== src/tcdm_cluster_top.sv ====
//******************************
// TCDM cluster top
// Crossbar, word-interleaved banks and response router
//******************************

`timescale 1ns/100ps
`default_nettype none

module tcdm_cluster_top
#(
   parameter int N_MASTERS = 4,
   parameter int N_BANKS   = 8,
   parameter int ROW_WIDTH = 6
)
(
   input  logic                            clk_i,
   input  logic                            reset_i,

   // Master ports
   input  logic [N_MASTERS-1:0]            req_i,
   input  tcdm_pkg::addr_t [N_MASTERS-1:0] add_i,
   input  logic [N_MASTERS-1:0]            wen_i,
   input  tcdm_pkg::data_t [N_MASTERS-1:0] wdata_i,
   input  tcdm_pkg::be_t [N_MASTERS-1:0]   be_i,
   output logic [N_MASTERS-1:0]            gnt_o,
   output logic [N_MASTERS-1:0]            r_valid_o,
   output tcdm_pkg::data_t [N_MASTERS-1:0] r_rdata_o
);

   import tcdm_pkg::*;

   // Bank select width
   localparam int BANK_SEL = (N_BANKS > 1) ? $clog2(N_BANKS) : 1;

   // Target bank of each master, to the response router
   logic [N_MASTERS-1:0][BANK_SEL-1:0] gnt_bank;

   // Crossbar to banks
   logic [N_BANKS-1:0]                 bank_req;
   logic [N_BANKS-1:0]                 bank_wen;
   logic [N_BANKS-1:0][ROW_WIDTH-1:0]  bank_row;
   data_t [N_BANKS-1:0]                bank_wdata;
   be_t [N_BANKS-1:0]                  bank_be;
   data_t [N_BANKS-1:0]                bank_rdata;

   //******************************
   // Crossbar
   //******************************

   tcdm_xbar
   #(
      .N_MASTERS    ( N_MASTERS  ),
      .N_BANKS      ( N_BANKS    ),
      .ROW_WIDTH    ( ROW_WIDTH  )
   )
   u_tcdm_xbar
   (
      .clk_i        ( clk_i      ),
      .reset_i      ( reset_i    ),
      .req_i        ( req_i      ),
      .add_i        ( add_i      ),
      .wen_i        ( wen_i      ),
      .wdata_i      ( wdata_i    ),
      .be_i         ( be_i       ),
      .gnt_o        ( gnt_o      ),
      .gnt_bank_o   ( gnt_bank   ),
      .bank_req_o   ( bank_req   ),
      .bank_wen_o   ( bank_wen   ),
      .bank_row_o   ( bank_row   ),
      .bank_wdata_o ( bank_wdata ),
      .bank_be_o    ( bank_be    )
   );

   //******************************
   // Banks
   //******************************

   for (genvar b = 0; b < N_BANKS; b++)
   begin : g_bank
      tcdm_sram_bank
      #(
         .ROW_WIDTH ( ROW_WIDTH     )
      )
      u_tcdm_sram_bank
      (
         .clk_i     ( clk_i         ),
         .req_i     ( bank_req[b]   ),
         .wen_i     ( bank_wen[b]   ),
         .row_i     ( bank_row[b]   ),
         .wdata_i   ( bank_wdata[b] ),
         .be_i      ( bank_be[b]    ),
         .rdata_o   ( bank_rdata[b] )
      );
   end

   // Response path, one cycle after the grant
   tcdm_resp_router
   #(
      .N_MASTERS    ( N_MASTERS  ),
      .N_BANKS      ( N_BANKS    )
   )
   u_tcdm_resp_router
   (
      .clk_i        ( clk_i      ),
      .reset_i      ( reset_i    ),
      .gnt_i        ( gnt_o      ),
      .gnt_bank_i   ( gnt_bank   ),
      .bank_rdata_i ( bank_rdata ),
      .r_valid_o    ( r_valid_o  ),
      .r_rdata_o    ( r_rdata_o  )
   );

endmodule

`default_nettype wire

// ==== src/tcdm_xbar.sv ====
//******************************
// TCDM crossbar
// Address decode, per-bank arbitration, payload mux and grant return
//******************************

`timescale 1ns/100ps
`default_nettype none

module tcdm_xbar
#(
   parameter int N_MASTERS = 4,
   parameter int N_BANKS   = 8,
   parameter int ROW_WIDTH = 6,
   // Bank select width
   localparam int BANK_SEL = (N_BANKS > 1) ? $clog2(N_BANKS) : 1
)
(
   input  logic                               clk_i,
   input  logic                               reset_i,

   // Master request side
   input  logic [N_MASTERS-1:0]               req_i,
   input  tcdm_pkg::addr_t [N_MASTERS-1:0]    add_i,
   input  logic [N_MASTERS-1:0]               wen_i,
   input  tcdm_pkg::data_t [N_MASTERS-1:0]    wdata_i,
   input  tcdm_pkg::be_t [N_MASTERS-1:0]      be_i,
   output logic [N_MASTERS-1:0]               gnt_o,
   output logic [N_MASTERS-1:0][BANK_SEL-1:0] gnt_bank_o,

   // Bank side
   output logic [N_BANKS-1:0]                 bank_req_o,
   output logic [N_BANKS-1:0]                 bank_wen_o,
   output logic [N_BANKS-1:0][ROW_WIDTH-1:0]  bank_row_o,
   output tcdm_pkg::data_t [N_BANKS-1:0]      bank_wdata_o,
   output tcdm_pkg::be_t [N_BANKS-1:0]        bank_be_o
);

   import tcdm_pkg::*;

   // First row bit of a byte address
   localparam int ROW_LSB  = BYTE_OFFSET + BANK_SEL;

   // Decoded target of each master
   logic [N_MASTERS-1:0][BANK_SEL-1:0]  master_bank;
   logic [N_MASTERS-1:0][ROW_WIDTH-1:0] master_row;

   // Per bank request and one-hot grant, indexed by master
   logic [N_BANKS-1:0][N_MASTERS-1:0]   bank_reqs;
   logic [N_BANKS-1:0][N_MASTERS-1:0]   bank_gnts;

   //******************************
   // Address decode
   //******************************

   // Word interleaved, bank bits just above the byte offset
   always_comb
   begin
      for (int m = 0; m < N_MASTERS; m++)
      begin
         master_bank[m] = add_i[m][BYTE_OFFSET +: BANK_SEL];
         master_row[m]  = add_i[m][ROW_LSB +: ROW_WIDTH];
      end
   end

   assign gnt_bank_o = master_bank;

   // Request vector seen by each bank
   always_comb
   begin
      bank_reqs = '0;
      for (int b = 0; b < N_BANKS; b++)
      begin
         for (int m = 0; m < N_MASTERS; m++)
            bank_reqs[b][m] = req_i[m] && (master_bank[m] == BANK_SEL'(b));
      end
   end

   //******************************
   // Bank arbiters
   //******************************

   for (genvar b = 0; b < N_BANKS; b++)
   begin : g_arb
      tcdm_rr_arbiter
      #(
         .N_MASTERS ( N_MASTERS    )
      )
      u_arbiter
      (
         .clk_i     ( clk_i        ),
         .reset_i   ( reset_i      ),
         .req_i     ( bank_reqs[b] ),
         .gnt_o     ( bank_gnts[b] )
      );
   end

   //******************************
   // Bank payload mux
   //******************************

   // AND-OR mux, at most one winner per bank
   always_comb
   begin
      bank_req_o   = '0;
      bank_wen_o   = '0;
      bank_row_o   = '0;
      bank_wdata_o = '0;
      bank_be_o    = '0;
      for (int b = 0; b < N_BANKS; b++)
      begin
         bank_req_o[b] = |bank_reqs[b];
         for (int m = 0; m < N_MASTERS; m++)
         begin
            if (bank_gnts[b][m])
            begin
               bank_wen_o[b]   = wen_i[m];
               bank_row_o[b]   = master_row[m];
               bank_wdata_o[b] = wdata_i[m];
               bank_be_o[b]    = be_i[m];
            end
         end
      end
   end

   //******************************
   // Grant return
   //******************************

   // Each master listens to the arbiter of its own target bank
   always_comb
   begin
      for (int m = 0; m < N_MASTERS; m++)
         gnt_o[m] = bank_gnts[master_bank[m]][m];
   end

endmodule

`default_nettype wire

// ==== src/tcdm_resp_router.sv ====
//******************************
// TCDM response router
// Returns r_valid and read data to each master
//******************************

`timescale 1ns/100ps
`default_nettype none

module tcdm_resp_router
#(
   parameter int N_MASTERS = 4,
   parameter int N_BANKS   = 8,
   // Bank select width
   localparam int BANK_SEL = (N_BANKS > 1) ? $clog2(N_BANKS) : 1
)
(
   input  logic                                   clk_i,
   input  logic                                   reset_i,
   input  logic [N_MASTERS-1:0]                   gnt_i,
   input  logic [N_MASTERS-1:0][BANK_SEL-1:0]     gnt_bank_i,
   input  tcdm_pkg::data_t [N_BANKS-1:0]          bank_rdata_i,
   output logic [N_MASTERS-1:0]                   r_valid_o,
   output tcdm_pkg::data_t [N_MASTERS-1:0]        r_rdata_o
);

   // Access granted last cycle
   logic [N_MASTERS-1:0]               valid_q;
   // Bank that served it
   logic [N_MASTERS-1:0][BANK_SEL-1:0] bank_q;

   //******************************
   // Response tracking
   //******************************

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
         valid_q <= '0;
      else
         valid_q <= gnt_i;
   end

   // Target bank of each master, one cycle late
   always_ff @(posedge clk_i)
   begin
      bank_q <= gnt_bank_i;
   end

   //******************************
   // Read data selection
   //******************************

   assign r_valid_o = valid_q;

   // Bank word from the registered bank, undefined after a write
   always_comb
   begin
      for (int m = 0; m < N_MASTERS; m++)
         r_rdata_o[m] = bank_rdata_i[bank_q[m]];
   end

endmodule

`default_nettype wire

// ==== src/tcdm_sram_bank.sv ====
//******************************
// TCDM bank
// Synchronous SRAM with byte-enabled write
//******************************

`timescale 1ns/100ps
`default_nettype none

module tcdm_sram_bank
#(
   parameter int ROW_WIDTH = 6
)
(
   input  logic                 clk_i,
   input  logic                 req_i,
   input  logic                 wen_i,
   input  logic [ROW_WIDTH-1:0] row_i,
   input  tcdm_pkg::data_t      wdata_i,
   input  tcdm_pkg::be_t        be_i,
   output tcdm_pkg::data_t      rdata_o
);

   import tcdm_pkg::*;

   // Bits covered by one byte enable
   localparam int LANE_WIDTH = DATA_WIDTH / BE_WIDTH;
   localparam int DEPTH      = 2 ** ROW_WIDTH;

   // Bank storage
   data_t mem_q [DEPTH];

   always_ff @(posedge clk_i)
   begin
      // Write, wen low, only the enabled lanes
      if (req_i && !wen_i)
      begin
         for (int b = 0; b < BE_WIDTH; b++)
         begin
            if (be_i[b])
               mem_q[row_i][b*LANE_WIDTH +: LANE_WIDTH] <= wdata_i[b*LANE_WIDTH +: LANE_WIDTH];
         end
      end
      // Read word lands one cycle later
      if (req_i && wen_i)
         rdata_o <= mem_q[row_i];
   end

endmodule

`default_nettype wire

// ==== src/tcdm_rr_arbiter.sv ====
//******************************
// TCDM bank arbiter
// Round-robin grant of one master per cycle
//******************************

`timescale 1ns/100ps
`default_nettype none

module tcdm_rr_arbiter
#(
   parameter int N_MASTERS = 4
)
(
   input  logic                 clk_i,
   input  logic                 reset_i,
   input  logic [N_MASTERS-1:0] req_i,
   output logic [N_MASTERS-1:0] gnt_o
);

   // Pointer wide enough for a master index
   localparam int PTR_WIDTH = (N_MASTERS > 1) ? $clog2(N_MASTERS) : 1;

   // Highest priority master this cycle
   logic [PTR_WIDTH-1:0] ptr_q;
   logic [PTR_WIDTH-1:0] ptr_d;
   logic [PTR_WIDTH-1:0] winner;
   logic                 any_req;

   //******************************
   // Winner selection
   //******************************

   // Scan downwards so the first requester above the pointer wins
   always_comb
   begin : pick
      int idx;
      any_req = |req_i;
      winner  = ptr_q;
      gnt_o   = '0;
      for (int k = N_MASTERS - 1; k >= 0; k--)
      begin
         idx = int'(ptr_q) + k;
         // Wrap around past the last master
         if (idx >= N_MASTERS)
            idx = idx - N_MASTERS;
         if (req_i[idx])
            winner = PTR_WIDTH'(idx);
      end
      // One-hot grant, only with a live request
      gnt_o[winner] = any_req;
   end

   // Next pointer is one past the winner
   assign ptr_d = (winner == PTR_WIDTH'(N_MASTERS - 1)) ? '0 : winner + 1'b1;

   //******************************
   // Pointer register
   //******************************

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
         ptr_q <= '0;
      else if (any_req)
         ptr_q <= ptr_d;
   end

endmodule

`default_nettype wire

// ==== src/tcdm_pkg.sv ====
//******************************
// TCDM bus definitions
// Word, byte enable and address types of the master bus
//******************************

`default_nettype none

package tcdm_pkg;

   //******************************
   // Bus widths
   //******************************

   // Master bus and bank word
   localparam int DATA_WIDTH = 32;

   // One enable per byte lane
   localparam int BE_WIDTH = DATA_WIDTH / 8;

   // Master byte address
   localparam int ADDR_WIDTH = 32;

   //******************************
   // Address fields
   //******************************

   // Byte offset inside a word, never used for routing
   localparam int BYTE_OFFSET = 2;

   //******************************
   // Bus types
   //******************************

   // One bus word
   typedef logic [DATA_WIDTH-1:0] data_t;

   // Byte enables of one word
   typedef logic [BE_WIDTH-1:0] be_t;

   // One byte address
   typedef logic [ADDR_WIDTH-1:0] addr_t;

endpackage

`default_nettype wire
